/* verilog/capture_cfg.svh */
`ifndef CAPTURE_CFG_SVH
`define CAPTURE_CFG_SVH

// window ring, 8 slots
`define CAP_WIN_DEPTH 8
`define CAP_WIN_IDX 3

// sample and memory word width
`define CAP_DATA_W 32

// block memory, 32 data entries plus the marker entry
`define CAP_BLK_DEPTH 32
`define CAP_BLK_IDX 6

// apb byte address width
`define CAP_APB_AW 10

// status word, read only
`define CAP_STATUS_ADDR 10'h3F8
// clear register, write only
`define CAP_CLEAR_ADDR 10'h3FC

// closing word of a filled block
`define CAP_MARKER {`CAP_DATA_W{1'b1}}

`endif

/* verilog/capture_pkg.sv */
`include "capture_cfg.svh"

package capture_pkg;

	// one recorded word
	typedef logic [`CAP_DATA_W-1:0] sample_t;

	// slot index into the window ring
	typedef logic [`CAP_WIN_IDX-1:0] win_ptr_t;

	// block memory address, 0..32
	typedef logic [`CAP_BLK_IDX-1:0] blk_addr_t;

	// recorder control states
	typedef enum logic [2:0] {
		IDLE  = 3'd0,
		// one cycle after an accept, window outputs settled
		CHECK = 3'd1,
		// filling the rest of a partial block
		PAD   = 3'd2,
		// writing the closing marker
		MARK  = 3'd3,
		// block complete, waiting for clear
		DONE  = 3'd4
	} ctrl_state_t;

endpackage

/* verilog/sample_ram.sv */
`timescale 1ns/1ps

module sample_ram import capture_pkg::*;
#(
	parameter int DEPTH = 8
)
(
	input  logic                     clk,
	// write port
	input  logic                     we_i,
	input  logic [$clog2(DEPTH)-1:0] waddr_i,
	input  sample_t                  wdata_i,
	// registered read port
	input  logic [$clog2(DEPTH)-1:0] raddr_i,
	output sample_t                  rdata_o
);

	// storage, no reset
	sample_t mem [DEPTH];

	always_ff @(posedge clk)
	begin
		if (we_i)
		begin
			mem[waddr_i] <= wdata_i;
		end
		// read before write on a shared slot
		// addresses past the last entry read as zero
		if (raddr_i < DEPTH)
		begin
			rdata_o <= mem[raddr_i];
		end
		else
		begin
			rdata_o <= '0;
		end
	end

endmodule

/* verilog/window_buffer.sv */
`timescale 1ns/1ps
`include "capture_cfg.svh"

module window_buffer import capture_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	// one strobe per accepted sample
	input  logic                      write_i,
	input  sample_t                   sample_data_i,
	input  logic                      sample_tag_i,
	// tag of the latest sample in each slot
	output logic [`CAP_WIN_DEPTH-1:0] flags_o,
	output logic                      armed_o,
	output logic                      quiet_o,
	// word at the post-write pointer
	output sample_t                   oldest_o
);

	// run counter saturates at the window depth
	localparam logic [`CAP_WIN_IDX:0] RUN_FULL = `CAP_WIN_DEPTH;
	localparam logic [`CAP_WIN_IDX:0] RUN_LAST = `CAP_WIN_DEPTH - 1;

	// next slot to write
	win_ptr_t wr_ptr;
	win_ptr_t wr_ptr_nxt;
	logic [`CAP_WIN_DEPTH-1:0] flags_nxt;
	// consecutive tagged samples
	logic [`CAP_WIN_IDX:0] run_cnt;
	logic run_full;

	// pointer and flags after this cycle's write
	always_comb
	begin
		wr_ptr_nxt = wr_ptr;
		flags_nxt = flags_o;
		if (write_i)
		begin
			// ring of 8, pointer wraps by itself
			wr_ptr_nxt = wr_ptr + 1'b1;
			flags_nxt[wr_ptr] = sample_tag_i;
		end
	end

	// eighth tagged sample in a row arrives now
	assign run_full = write_i && sample_tag_i && (run_cnt == RUN_LAST);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			flags_o <= '0;
			run_cnt <= '0;
			armed_o <= 1'b0;
		end
		else
		begin
			wr_ptr <= wr_ptr_nxt;
			flags_o <= flags_nxt;
			if (write_i)
			begin
				// untagged sample breaks the run
				if (!sample_tag_i)
				begin
					run_cnt <= '0;
				end
				else if (run_cnt != RUN_FULL)
				begin
					run_cnt <= run_cnt + 1'b1;
				end
			end
			// armed holds until the whole window goes untagged
			if (run_full)
			begin
				armed_o <= 1'b1;
			end
			else if (flags_nxt == '0)
			begin
				armed_o <= 1'b0;
			end
		end
	end

	// no tagged sample left in the window
	assign quiet_o = (flags_o == '0);

	// sample storage, read at the post-write pointer
	sample_ram #(
		.DEPTH(`CAP_WIN_DEPTH)
	) ring_ram_inst (
		.clk     (clk),
		.we_i    (write_i),
		.waddr_i (wr_ptr),
		.wdata_i (sample_data_i),
		.raddr_i (wr_ptr_nxt),
		.rdata_o (oldest_o)
	);

endmodule

/* verilog/capture_ctrl.sv */
`timescale 1ns/1ps
`include "capture_cfg.svh"

module capture_ctrl import capture_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	// sample handshake
	input  logic      sample_valid_i,
	output logic      sample_ready_o,
	// window write strobe, same as accept
	output logic      win_write_o,
	// window status, valid in CHECK
	input  logic      armed_i,
	input  logic      quiet_i,
	input  sample_t   oldest_i,
	// clear pulse from apb
	input  logic      clear_i,
	// block memory write port
	output logic      blk_we_o,
	output blk_addr_t blk_waddr_o,
	output sample_t   blk_wdata_o,
	// entries written so far
	output blk_addr_t blk_count_o,
	output logic      done_o
);

	// last data entry and marker entry
	localparam blk_addr_t BLK_LAST = `CAP_BLK_DEPTH - 1;
	localparam blk_addr_t BLK_MARK = `CAP_BLK_DEPTH;

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	blk_addr_t blk_count;
	// oldest word goes to the block this cycle
	logic rec_write;
	// partial block that may be padded
	logic pad_ok;

	// accepts only in IDLE, one sample in flight
	assign sample_ready_o = (state == IDLE);
	assign win_write_o = sample_valid_i && sample_ready_o;
	assign done_o = (state == DONE);
	assign blk_count_o = blk_count;

	assign rec_write = (state == CHECK) && armed_i && (blk_count < BLK_MARK);
	assign pad_ok = quiet_i && (blk_count != '0) && (blk_count < BLK_MARK);

	// next state
	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:
			begin
				if (win_write_o)
				begin
					state_nxt = CHECK;
				end
			end
			CHECK:
			begin
				// record first, then pad check
				if (rec_write)
				begin
					state_nxt = (blk_count == BLK_LAST) ? MARK : IDLE;
				end
				else if (pad_ok)
				begin
					state_nxt = PAD;
				end
				else
				begin
					state_nxt = IDLE;
				end
			end
			PAD:
			begin
				// one entry per cycle until 32 exist
				if (blk_count == BLK_LAST)
				begin
					state_nxt = MARK;
				end
			end
			MARK:
			begin
				state_nxt = DONE;
			end
			DONE:
			begin
				if (clear_i)
				begin
					state_nxt = IDLE;
				end
			end
			default:
			begin
				state_nxt = IDLE;
			end
		endcase
	end

	// block write port
	always_comb
	begin
		blk_we_o = 1'b0;
		blk_waddr_o = blk_count;
		blk_wdata_o = oldest_i;
		case (state)
			CHECK:
			begin
				blk_we_o = rec_write;
			end
			PAD:
			begin
				// pad entry holds its own index
				blk_we_o = 1'b1;
				blk_wdata_o = sample_t'(blk_count);
			end
			MARK:
			begin
				blk_we_o = 1'b1;
				blk_waddr_o = BLK_MARK;
				blk_wdata_o = `CAP_MARKER;
			end
			default:
			begin
				blk_we_o = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			blk_count <= '0;
		end
		else
		begin
			state <= state_nxt;
			// clear starts a new block
			if ((state == DONE) && clear_i)
			begin
				blk_count <= '0;
			end
			else if (rec_write || (state == PAD))
			begin
				blk_count <= blk_count + 1'b1;
			end
		end
	end

endmodule

/* verilog/apb_readout.sv */
`timescale 1ns/1ps
`include "capture_cfg.svh"

module apb_readout import capture_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	// apb slave
	input  logic [`CAP_APB_AW-1:0] paddr_i,
	input  logic                   psel_i,
	input  logic                   penable_i,
	input  logic                   pwrite_i,
	input  sample_t                pwdata_i,
	output sample_t                prdata_o,
	output logic                   pready_o,
	output logic                   pslverr_o,
	// block memory read port
	output blk_addr_t              blk_raddr_o,
	input  sample_t                blk_rdata_i,
	// recorder status
	input  blk_addr_t              blk_count_i,
	input  logic                   done_i,
	output logic                   clear_o
);

	// highest block entry as a word index
	localparam logic [`CAP_APB_AW-3:0] LAST_ENTRY = `CAP_BLK_DEPTH;

	logic access;
	logic is_blk;
	logic is_status;
	logic is_clear;
	logic blk_rd;
	logic addr_err;
	// wait state of a block read has passed
	logic wait_q;
	sample_t status_word;

	// access phase of a transfer
	assign access = psel_i && penable_i;

	// address decode
	// block entries are word aligned, 0 to 32
	assign is_blk = (paddr_i[1:0] == 2'b00) && (paddr_i[`CAP_APB_AW-1:2] <= LAST_ENTRY);
	assign is_status = (paddr_i == `CAP_STATUS_ADDR);
	assign is_clear = (paddr_i == `CAP_CLEAR_ADDR);
	assign blk_rd = !pwrite_i && is_blk;

	// only the clear register is writable
	assign addr_err = pwrite_i ? !is_clear : !(is_blk || is_status);

	// word index straight from the bus
	assign blk_raddr_o = paddr_i[`CAP_BLK_IDX+1:2];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wait_q <= 1'b0;
		end
		else
		begin
			// high for the second access cycle of a block read
			wait_q <= access && blk_rd && !wait_q;
		end
	end

	// one wait state on block reads, none otherwise
	assign pready_o = access && (!blk_rd || wait_q);
	assign pslverr_o = access && addr_err;

	// single access cycle, so a one-cycle pulse
	assign clear_o = access && pwrite_i && is_clear && pwdata_i[0];

	// done in bit 0, count in 13:8
	always_comb
	begin
		status_word = '0;
		status_word[0] = done_i;
		status_word[8 +: `CAP_BLK_IDX] = blk_count_i;
	end

	// read data mux
	always_comb
	begin
		prdata_o = '0;
		if (blk_rd)
		begin
			prdata_o = blk_rdata_i;
		end
		else if (!pwrite_i && is_status)
		begin
			prdata_o = status_word;
		end
	end

endmodule

/* verilog/capture_top.sv */
`timescale 1ns/1ps
`include "capture_cfg.svh"

module capture_top import capture_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	// sample port
	input  logic                      sample_valid_i,
	output logic                      sample_ready_o,
	input  sample_t                   sample_data_i,
	input  logic                      sample_tag_i,
	// window tags and block state
	output logic [`CAP_WIN_DEPTH-1:0] flag_o,
	output logic                      done_o,
	// apb slave
	input  logic [`CAP_APB_AW-1:0]    paddr_i,
	input  logic                      psel_i,
	input  logic                      penable_i,
	input  logic                      pwrite_i,
	input  sample_t                   pwdata_i,
	output sample_t                   prdata_o,
	output logic                      pready_o,
	output logic                      pslverr_o
);

	// window to controller
	logic win_write;
	logic armed;
	logic quiet;
	sample_t oldest;
	// controller to block memory
	logic blk_we;
	blk_addr_t blk_waddr;
	sample_t blk_wdata;
	blk_addr_t blk_count;
	// block memory to apb
	blk_addr_t blk_raddr;
	sample_t blk_rdata;
	logic clear;

	window_buffer window_buffer_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.write_i       (win_write),
		.sample_data_i (sample_data_i),
		.sample_tag_i  (sample_tag_i),
		.flags_o       (flag_o),
		.armed_o       (armed),
		.quiet_o       (quiet),
		.oldest_o      (oldest)
	);

	capture_ctrl capture_ctrl_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.sample_valid_i (sample_valid_i),
		.sample_ready_o (sample_ready_o),
		.win_write_o    (win_write),
		.armed_i        (armed),
		.quiet_i        (quiet),
		.oldest_i       (oldest),
		.clear_i        (clear),
		.blk_we_o       (blk_we),
		.blk_waddr_o    (blk_waddr),
		.blk_wdata_o    (blk_wdata),
		.blk_count_o    (blk_count),
		.done_o         (done_o)
	);

	// block memory, data entries plus the marker
	sample_ram #(
		.DEPTH(`CAP_BLK_DEPTH + 1)
	) block_ram_inst (
		.clk     (clk),
		.we_i    (blk_we),
		.waddr_i (blk_waddr),
		.wdata_i (blk_wdata),
		.raddr_i (blk_raddr),
		.rdata_o (blk_rdata)
	);

	apb_readout apb_readout_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.paddr_i     (paddr_i),
		.psel_i      (psel_i),
		.penable_i   (penable_i),
		.pwrite_i    (pwrite_i),
		.pwdata_i    (pwdata_i),
		.prdata_o    (prdata_o),
		.pready_o    (pready_o),
		.pslverr_o   (pslverr_o),
		.blk_raddr_o (blk_raddr),
		.blk_rdata_i (blk_rdata),
		.blk_count_i (blk_count),
		.done_i      (done_o),
		.clear_o     (clear)
	);

endmodule

/* tests/capture_tb.sv */
`timescale 1ns/1ps
`include "capture_cfg.svh"

module capture_tb import capture_pkg::*;
();

	// wait limits in clock cycles
	localparam int HANDSHAKE_LIMIT = 100;
	localparam int DONE_LIMIT = 100;
	localparam int APB_LIMIT = 10;
	localparam int HOLD_CYCLES = 16;
	localparam int MAX_SAMPLES = 2000;

	logic clk;
	logic rst_n;
	// sample port
	logic sample_valid;
	logic sample_ready;
	sample_t sample_data;
	logic sample_tag;
	logic [`CAP_WIN_DEPTH-1:0] flag;
	logic done;
	// apb master side
	logic [`CAP_APB_AW-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	sample_t pwdata;
	sample_t prdata;
	logic pready;
	logic pslverr;

	int errors;
	int timeouts;
	logic [15:0] lfsr_state;

	// reference model state
	sample_t ring_m [`CAP_WIN_DEPTH];
	logic [`CAP_WIN_DEPTH-1:0] flags_m;
	int accepts_m;
	int run_m;
	logic armed_m;
	sample_t block_m [`CAP_BLK_DEPTH + 1];
	int count_m;
	logic done_m;
	// first padded entry of the current block or -1
	int pad_from_m;

	capture_top capture_top_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.sample_valid_i (sample_valid),
		.sample_ready_o (sample_ready),
		.sample_data_i  (sample_data),
		.sample_tag_i   (sample_tag),
		.flag_o         (flag),
		.done_o         (done),
		.paddr_i        (paddr),
		.psel_i         (psel),
		.penable_i      (penable),
		.pwrite_i       (pwrite),
		.pwdata_i       (pwdata),
		.prdata_o       (prdata),
		.pready_o       (pready),
		.pslverr_o      (pslverr)
	);

	initial
	begin
		clk = 1'b0;
	end

	// 10 ns period
	always #5 clk = ~clk;

	// galois lfsr for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic next_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
		begin
			lfsr_state = lfsr_state ^ 16'hB400;
		end
		return out;
	endfunction

	// one lfsr step per bit
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			v = {v[30:0], next_bit()};
		end
		return v;
	endfunction

	// model update for one accepted sample
	task automatic apply_accept(input sample_t data, input logic tag);
		int slot;
		int k;
		sample_t oldest;
		slot = accepts_m % `CAP_WIN_DEPTH;
		ring_m[slot] = data;
		flags_m[slot] = tag;
		accepts_m++;
		// oldest entry sits right after the newest
		oldest = ring_m[(slot + 1) % `CAP_WIN_DEPTH];
		// eighth tagged in a row arms and an empty window disarms
		if (tag && (run_m == `CAP_WIN_DEPTH - 1))
		begin
			armed_m = 1'b1;
		end
		else if (flags_m == '0)
		begin
			armed_m = 1'b0;
		end
		if (!tag)
		begin
			run_m = 0;
		end
		else if (run_m < `CAP_WIN_DEPTH)
		begin
			run_m++;
		end
		// check cycle decision
		if (armed_m && (count_m < `CAP_BLK_DEPTH))
		begin
			block_m[count_m] = oldest;
			count_m++;
		end
		else if ((flags_m == '0) && (count_m > 0) && (count_m < `CAP_BLK_DEPTH))
		begin
			pad_from_m = count_m;
			for (k = count_m; k < `CAP_BLK_DEPTH; k++)
			begin
				block_m[k] = sample_t'(k);
			end
			count_m = `CAP_BLK_DEPTH;
		end
		else
		begin
			return;
		end
		// full block gets the marker
		if (count_m == `CAP_BLK_DEPTH)
		begin
			block_m[`CAP_BLK_DEPTH] = `CAP_MARKER;
			done_m = 1'b1;
		end
	endtask

	// offer one sample and compare flags after the accept
	task automatic send_sample(input sample_t data, input logic tag);
		int waited;
		logic accepted;
		@(posedge clk);
		sample_valid <= 1'b1;
		sample_data <= data;
		sample_tag <= tag;
		waited = 0;
		accepted = 1'b0;
		while (!accepted && (waited < HANDSHAKE_LIMIT))
		begin
			@(posedge clk);
			accepted = sample_ready;
			waited++;
		end
		sample_valid <= 1'b0;
		if (!accepted)
		begin
			$display("sample was not accepted within %0d cycles at t=%0t", HANDSHAKE_LIMIT,
				$time);
			timeouts++;
		end
		else
		begin
			apply_accept(data, tag);
			@(negedge clk);
			if (flag !== flags_m)
			begin
				$display("[ERROR] t=%0t flag_o got %b expected %b", $time, flag, flags_m);
				errors++;
			end
		end
	endtask

	// one apb transfer with setup then access until pready
	task automatic bus_transfer(
		input logic [`CAP_APB_AW-1:0] addr,
		input logic write,
		input sample_t wdata,
		output sample_t rdata,
		output logic err
	);
		int waited;
		int cycles_exp;
		logic ready_seen;
		// block reads take one wait state, all else completes at once
		if (!write && (addr[1:0] == 2'b00) && (addr[`CAP_APB_AW-1:2] <= `CAP_BLK_DEPTH))
		begin
			cycles_exp = 2;
		end
		else
		begin
			cycles_exp = 1;
		end
		@(posedge clk);
		paddr <= addr;
		pwrite <= write;
		pwdata <= wdata;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge clk);
		penable <= 1'b1;
		waited = 0;
		ready_seen = 1'b0;
		while (!ready_seen && (waited < APB_LIMIT))
		begin
			@(posedge clk);
			ready_seen = pready;
			waited++;
		end
		rdata = prdata;
		err = pslverr;
		psel <= 1'b0;
		penable <= 1'b0;
		if (!ready_seen)
		begin
			$display("apb transfer to %h got no pready within %0d cycles", addr, APB_LIMIT);
			timeouts++;
		end
		else if (waited != cycles_exp)
		begin
			$display("[ERROR] t=%0t pready_o access cycles got %0d expected %0d", $time,
				waited, cycles_exp);
			errors++;
		end
	endtask

	task automatic wait_done();
		int waited;
		waited = 0;
		@(negedge clk);
		while ((done !== 1'b1) && (waited < DONE_LIMIT))
		begin
			@(negedge clk);
			waited++;
		end
		if (done !== 1'b1)
		begin
			$display("done_o did not rise within %0d cycles at t=%0t", DONE_LIMIT, $time);
			timeouts++;
		end
	endtask

	// status word with done in bit 0 and count in 13:8
	task automatic check_status();
		sample_t rd;
		sample_t exp;
		logic err;
		exp = '0;
		exp[0] = done_m;
		exp[13:8] = count_m[5:0];
		bus_transfer(`CAP_STATUS_ADDR, 1'b0, '0, rd, err);
		if (err !== 1'b0)
		begin
			$display("[ERROR] t=%0t pslverr_o got %b expected 0", $time, err);
			errors++;
		end
		if (rd !== exp)
		begin
			$display("[ERROR] t=%0t prdata_o status got %h expected %h", $time, rd, exp);
			errors++;
		end
	endtask

	// every block entry and the marker through apb
	task automatic check_block();
		int e;
		sample_t rd;
		logic err;
		logic [`CAP_APB_AW-1:0] addr;
		for (e = 0; (e <= `CAP_BLK_DEPTH) && (timeouts == 0); e++)
		begin
			addr = {e[`CAP_APB_AW-3:0], 2'b00};
			bus_transfer(addr, 1'b0, '0, rd, err);
			if (err !== 1'b0)
			begin
				$display("[ERROR] t=%0t pslverr_o got %b expected 0", $time, err);
				errors++;
			end
			if (rd !== block_m[e])
			begin
				$display("[ERROR] t=%0t prdata_o entry %0d got %h expected %h", $time, e, rd,
					block_m[e]);
				errors++;
			end
		end
		check_status();
	endtask

	// samples must wait while the block is done
	task automatic hold_while_done();
		int i;
		@(posedge clk);
		sample_valid <= 1'b1;
		sample_data <= random_bits(32);
		sample_tag <= 1'b1;
		for (i = 0; i < HOLD_CYCLES; i++)
		begin
			@(posedge clk);
			if (sample_ready !== 1'b0)
			begin
				$display("[ERROR] t=%0t sample_ready_o got %b expected 0", $time, sample_ready);
				errors++;
			end
		end
		sample_valid <= 1'b0;
	endtask

	task automatic record_full_block();
		int n;
		logic tag;
		sample_t data;
		n = 0;
		while (!done_m && (n < MAX_SAMPLES) && (timeouts == 0))
		begin
			data = random_bits(32);
			// mostly tagged with rare single drops
			tag = (random_bits(4) != 0);
			send_sample(data, tag);
			n++;
		end
		if (!done_m)
		begin
			$display("no block was completed after %0d samples", n);
			errors++;
		end
		else if (pad_from_m >= 0)
		begin
			$display("first block was padded instead of fully recorded");
			errors++;
		end
		if (timeouts == 0)
		begin
			wait_done();
		end
		if (timeouts == 0)
		begin
			check_block();
			hold_while_done();
		end
	endtask

	task automatic record_padded_block();
		int n;
		int i;
		n = 1 + int'(random_bits(4));
		for (i = 0; (i < n) && (timeouts == 0); i++)
		begin
			send_sample(random_bits(32), 1'b1);
		end
		// untagged samples empty the window
		for (i = 0; !done_m && (i < 2 * `CAP_WIN_DEPTH) && (timeouts == 0); i++)
		begin
			send_sample(random_bits(32), 1'b0);
		end
		if (pad_from_m <= 0)
		begin
			$display("second block was not padded");
			errors++;
		end
		if (timeouts == 0)
		begin
			wait_done();
		end
		if (timeouts == 0)
		begin
			check_block();
		end
	endtask

	// clear then the error responses
	task automatic clear_block();
		sample_t rd;
		logic err;
		bus_transfer(`CAP_CLEAR_ADDR, 1'b1, 32'd1, rd, err);
		if (err !== 1'b0)
		begin
			$display("[ERROR] t=%0t pslverr_o got %b expected 0", $time, err);
			errors++;
		end
		done_m = 1'b0;
		count_m = 0;
		pad_from_m = -1;
		@(negedge clk);
		if (done !== 1'b0)
		begin
			$display("[ERROR] t=%0t done_o got %b expected 0", $time, done);
			errors++;
		end
		check_status();
		// status is read only
		bus_transfer(`CAP_STATUS_ADDR, 1'b1, 32'd1, rd, err);
		if (err !== 1'b1)
		begin
			$display("[ERROR] t=%0t pslverr_o got %b expected 1", $time, err);
			errors++;
		end
		// entry 33 is past the block
		bus_transfer(10'h084, 1'b0, '0, rd, err);
		if (err !== 1'b1)
		begin
			$display("[ERROR] t=%0t pslverr_o got %b expected 1", $time, err);
			errors++;
		end
	endtask

	initial
	begin
		rst_n = 1'b0;
		sample_valid = 1'b0;
		sample_data = '0;
		sample_tag = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		errors = 0;
		timeouts = 0;
		lfsr_state = 16'd13359;
		foreach (ring_m[i])
		begin
			ring_m[i] = '0;
		end
		foreach (block_m[i])
		begin
			block_m[i] = '0;
		end
		flags_m = '0;
		accepts_m = 0;
		run_m = 0;
		armed_m = 1'b0;
		count_m = 0;
		done_m = 1'b0;
		pad_from_m = -1;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		// reset state
		if (sample_ready !== 1'b1)
		begin
			$display("[ERROR] t=%0t sample_ready_o got %b expected 1", $time, sample_ready);
			errors++;
		end
		if (done !== 1'b0)
		begin
			$display("[ERROR] t=%0t done_o got %b expected 0", $time, done);
			errors++;
		end
		if (flag !== '0)
		begin
			$display("[ERROR] t=%0t flag_o got %b expected 0", $time, flag);
			errors++;
		end
		if (pready !== 1'b0)
		begin
			$display("[ERROR] t=%0t pready_o got %b expected 0", $time, pready);
			errors++;
		end
		check_status();
		if (timeouts == 0)
		begin
			record_full_block();
		end
		if (timeouts == 0)
		begin
			clear_block();
		end
		if (timeouts == 0)
		begin
			record_padded_block();
		end
		if (timeouts == 0)
		begin
			clear_block();
		end
		$display("errors=%0d timeouts=%0d", errors, timeouts);
		if ((errors == 0) && (timeouts == 0))
		begin
			$display("=== PASS ===");
		end
		else
		begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* src.f */
+incdir+verilog
verilog/capture_pkg.sv
verilog/sample_ram.sv
verilog/window_buffer.sv
verilog/capture_ctrl.sv
verilog/apb_readout.sv
verilog/capture_top.sv
tests/capture_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module capture_tb -f src.f -o capture_sim
./obj_dir/capture_sim > sim.log
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
exit 0
